// File: logic/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// field layout of a 16-bit word address: tag, set, offset
`define ICACHE_WORD_BITS   16
`define ICACHE_TAG_BITS    12
`define ICACHE_SET_BITS    2
`define ICACHE_OFFSET_BITS 2

`define ICACHE_LINE_WORDS  4
`define ICACHE_NUM_SETS    4

`endif

// File: logic/icache_types_pkg.sv
`default_nettype none

`include "icache_params.svh"

package icache_types_pkg;

    typedef logic [`ICACHE_WORD_BITS-1:0] word_t; // instruction word or word address

    typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;

    typedef logic [`ICACHE_SET_BITS-1:0] set_t; // selects one of the lines

    typedef logic [`ICACHE_OFFSET_BITS-1:0] offset_t; // selects a word within a line

endpackage

`default_nettype wire

// File: logic/icache_ctrl_pkg.sv
`default_nettype none

`include "icache_params.svh"

package icache_ctrl_pkg;

    typedef enum logic [1:0] {IDLE, FILL, RESPOND} fill_state_t;

    typedef logic [`ICACHE_OFFSET_BITS:0] burst_count_t; // one bit wider so it can reach 4

endpackage

`default_nettype wire

// File: logic/icache_fill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_fill_ctrl (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      fetch,
    input  icache_types_pkg::word_t  fetch_addr,
    input  wire                      hit,
    input  wire                      burst_end,
    input  icache_types_pkg::offset_t issue_offset,
    output icache_types_pkg::tag_t   lookup_tag,
    output icache_types_pkg::set_t   lookup_set,
    output icache_types_pkg::tag_t   req_tag,
    output icache_types_pkg::set_t   req_set,
    output icache_types_pkg::set_t   read_set,
    output icache_types_pkg::offset_t read_offset,
    output icache_types_pkg::word_t  mem_addr,
    output logic                     burst_run,
    output logic                     tag_write,
    output logic                     load_out,
    output logic                     fetch_done
);
    import icache_types_pkg::*;
    import icache_ctrl_pkg::*;

    fill_state_t state;
    fill_state_t next_state;
    offset_t     req_offset;
    offset_t     lookup_offset;
    logic        accept;

    assign lookup_tag    = fetch_addr[`ICACHE_WORD_BITS-1 -: `ICACHE_TAG_BITS];
    assign lookup_set    = fetch_addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign lookup_offset = fetch_addr[0 +: `ICACHE_OFFSET_BITS];

    // a request is taken in IDLE once the previous response pulse is over
    assign accept = (state == IDLE) && fetch && !fetch_done;

    assign burst_run   = (state == FILL);
    assign tag_write   = (state == FILL) && burst_end;
    assign load_out    = (accept && hit) || (state == RESPOND);
    assign read_set    = (state == IDLE) ? lookup_set : req_set;
    assign read_offset = (state == IDLE) ? lookup_offset : req_offset;
    assign mem_addr    = {req_tag, req_set, issue_offset}; // aligned line base plus burst step

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (accept && !hit) next_state = FILL;
            FILL:    if (burst_end) next_state = RESPOND;
            RESPOND: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state      <= IDLE;
            fetch_done <= 1'b0;
        end else begin
            state      <= next_state;
            fetch_done <= load_out; // fetch_data is loaded on the same edge
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !hit) begin
            req_tag    <= lookup_tag;
            req_set    <= lookup_set;
            req_offset <= lookup_offset;
        end
    end

    a_single_done: assert property (@(posedge clk) disable iff (reset_n)
        fetch_done |=> !fetch_done);

endmodule

`default_nettype wire

// File: logic/burst_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module burst_counter (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       burst_run,
    output logic                      burst_issue,
    output icache_types_pkg::offset_t issue_offset,
    output logic                      fill_write,
    output icache_types_pkg::offset_t fill_offset,
    output logic                      burst_end
);
    import icache_ctrl_pkg::*;

    localparam burst_count_t LAST = burst_count_t'(`ICACHE_LINE_WORDS);

    burst_count_t count;
    burst_count_t count_m1;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            count <= '0;
        end else if (!burst_run) begin
            count <= '0;
        end else if (count != LAST) begin
            count <= count + burst_count_t'(1); // holds at the last step
        end
    end

    assign count_m1 = count - burst_count_t'(1);

    // memory data lags the read by one cycle, so writes trail the issue window
    assign burst_issue  = burst_run && (count < LAST);
    assign issue_offset = count[`ICACHE_OFFSET_BITS-1:0];
    assign fill_write   = burst_run && (count != '0);
    assign fill_offset  = count_m1[`ICACHE_OFFSET_BITS-1:0];
    assign burst_end    = burst_run && (count == LAST);

    a_issue_end_apart: assert property (@(posedge clk) disable iff (reset_n)
        !(burst_issue && burst_end));

endmodule

`default_nettype wire

// File: logic/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module tag_store (
    input  wire                    clk,
    input  wire                    reset_n,
    input  icache_types_pkg::tag_t lookup_tag,
    input  icache_types_pkg::set_t lookup_set,
    input  wire                    tag_write,
    input  icache_types_pkg::tag_t req_tag,
    input  icache_types_pkg::set_t req_set,
    output logic                   hit
);
    import icache_types_pkg::*;

    logic [`ICACHE_NUM_SETS-1:0] valid;
    tag_t                        tags [`ICACHE_NUM_SETS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid <= '0; // every line is invalid after reset
        end else if (tag_write) begin
            valid[req_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_write) begin
            tags[req_set] <= req_tag;
        end
    end

    assign hit = valid[lookup_set] && (tags[lookup_set] == lookup_tag);

    // a refill only happens for a line that missed
    a_no_redundant_fill: assert property (@(posedge clk) disable iff (reset_n)
        tag_write |-> !(valid[req_set] && (tags[req_set] == req_tag)));

endmodule

`default_nettype wire

// File: logic/line_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module line_store (
    input  wire                       clk,
    input  wire                       fill_write,
    input  icache_types_pkg::set_t    req_set,
    input  icache_types_pkg::offset_t fill_offset,
    input  icache_types_pkg::word_t   mem_data,
    input  icache_types_pkg::set_t    read_set,
    input  icache_types_pkg::offset_t read_offset,
    input  wire                       load_out,
    output icache_types_pkg::word_t   fetch_data
);
    import icache_types_pkg::*;

    localparam int DEPTH = `ICACHE_NUM_SETS * `ICACHE_LINE_WORDS;

    word_t                                          words [DEPTH];
    logic [`ICACHE_SET_BITS+`ICACHE_OFFSET_BITS-1:0] write_index;
    logic [`ICACHE_SET_BITS+`ICACHE_OFFSET_BITS-1:0] read_index;

    assign write_index = {req_set, fill_offset};
    assign read_index  = {read_set, read_offset};

    always_ff @(posedge clk) begin
        if (fill_write) begin
            words[write_index] <= mem_data; // one word of the burst per cycle
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            fetch_data <= words[read_index]; // held until the next response
        end
    end

endmodule

`default_nettype wire

// File: logic/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     fetch,
    input  icache_types_pkg::word_t fetch_addr,
    input  icache_types_pkg::word_t mem_data,
    output icache_types_pkg::word_t fetch_data,
    output logic                    fetch_done,
    output logic                    mem_read,
    output icache_types_pkg::word_t mem_addr
);
    import icache_types_pkg::*;

    tag_t    lookup_tag;
    set_t    lookup_set;
    tag_t    req_tag;
    set_t    req_set;
    set_t    read_set;
    offset_t read_offset;
    offset_t issue_offset;
    offset_t fill_offset;
    logic    hit;
    logic    burst_run;
    logic    burst_issue;
    logic    burst_end;
    logic    fill_write;
    logic    tag_write;
    logic    load_out;

    assign mem_read = burst_issue;

    icache_fill_ctrl icache_fill_ctrl_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .fetch        (fetch),
        .fetch_addr   (fetch_addr),
        .hit          (hit),
        .burst_end    (burst_end),
        .issue_offset (issue_offset),
        .lookup_tag   (lookup_tag),
        .lookup_set   (lookup_set),
        .req_tag      (req_tag),
        .req_set      (req_set),
        .read_set     (read_set),
        .read_offset  (read_offset),
        .mem_addr     (mem_addr),
        .burst_run    (burst_run),
        .tag_write    (tag_write),
        .load_out     (load_out),
        .fetch_done   (fetch_done)
    );

    burst_counter burst_counter_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .burst_run    (burst_run),
        .burst_issue  (burst_issue),
        .issue_offset (issue_offset),
        .fill_write   (fill_write),
        .fill_offset  (fill_offset),
        .burst_end    (burst_end)
    );

    tag_store tag_store_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .lookup_tag (lookup_tag),
        .lookup_set (lookup_set),
        .tag_write  (tag_write),
        .req_tag    (req_tag),
        .req_set    (req_set),
        .hit        (hit)
    );

    line_store line_store_inst (
        .clk         (clk),
        .fill_write  (fill_write),
        .req_set     (req_set),
        .fill_offset (fill_offset),
        .mem_data    (mem_data),
        .read_set    (read_set),
        .read_offset (read_offset),
        .load_out    (load_out),
        .fetch_data  (fetch_data)
    );

endmodule

`default_nettype wire

// File: tests/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_tb;
    import icache_types_pkg::*;

    localparam int FETCH_TIMEOUT = 20;

    logic  clk = 1'b0;
    logic  reset_n;
    logic  fetch;
    word_t fetch_addr;
    word_t mem_data = '0;
    word_t fetch_data;
    logic  fetch_done;
    logic  mem_read;
    word_t mem_addr;

    logic        ref_valid [`ICACHE_NUM_SETS];
    tag_t        ref_tag [`ICACHE_NUM_SETS];
    word_t       read_addrs [$]; // memory reads seen since the fetch started
    logic        read_pending = 1'b0;
    word_t       read_addr_q = '0;
    int          error_count = 0;
    int          check_count = 0;
    int unsigned seed_value;

    icache_top icache_top_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .fetch      (fetch),
        .fetch_addr (fetch_addr),
        .mem_data   (mem_data),
        .fetch_data (fetch_data),
        .fetch_done (fetch_done),
        .mem_read   (mem_read),
        .mem_addr   (mem_addr)
    );

    always #4 clk = ~clk;

    function automatic word_t rule_word(input word_t addr);
        return addr ^ 16'h5a3c;
    endfunction

    // external memory with one cycle of read latency
    // a read seen in one cycle puts its word on mem_data for the next cycle
    always @(negedge clk) begin
        if (read_pending) begin
            mem_data = rule_word(read_addr_q);
        end
        read_pending = mem_read;
        read_addr_q  = mem_addr;
        if (mem_read) begin
            read_addrs.push_back(mem_addr);
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic hold_reset();
        reset_n = 1'b1;
        fetch   = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value(32'(fetch_done), 32'd0, "fetch_done during reset");
            check_value(32'(mem_read), 32'd0, "mem_read during reset");
        end
        reset_n = 1'b0;
        for (int i = 0; i < `ICACHE_NUM_SETS; i++) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    // one fetch, checked against the reference model of the tags
    task automatic fetch_word(input word_t addr);
        tag_t  tag;
        set_t  set;
        word_t base;
        logic  expect_hit;
        int    cycles;
        tag        = addr[15:4];
        set        = addr[3:2];
        base       = {addr[15:2], 2'b00};
        expect_hit = ref_valid[set] && (ref_tag[set] == tag);
        @(negedge clk);
        read_addrs.delete();
        fetch      = 1'b1;
        fetch_addr = addr;
        cycles     = 0;
        while (!fetch_done && cycles < FETCH_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!fetch_done) begin
            $display("fetch_done did not arrive within %0d cycles for address %h",
                     FETCH_TIMEOUT, addr);
            $display("Test FAILED");
            $finish;
        end
        fetch = 1'b0;
        check_value(32'(cycles), expect_hit ? 32'd1 : 32'd7, "fetch latency");
        check_value(32'(fetch_data), 32'(rule_word(addr)), "fetch data");
        if (expect_hit) begin
            check_value(32'(read_addrs.size()), 32'd0, "memory reads on a hit");
        end else begin
            check_value(32'(read_addrs.size()), 32'd4, "memory reads on a miss");
            if (read_addrs.size() == 4) begin
                for (int i = 0; i < 4; i++) begin
                    check_value(32'(read_addrs[i]), 32'(base + word_t'(i)), "burst address");
                end
            end
            ref_valid[set] = 1'b1; // the line is now filled
            ref_tag[set]   = tag;
        end
    endtask

    task automatic cold_miss();
        fetch_word(16'h0125);
    endtask

    task automatic hit_after_fill();
        fetch_word(16'h0125);
    endtask

    task automatic same_line_hits();
        for (int i = 0; i < 4; i++) begin
            if (i != 1) begin
                fetch_word({14'(16'h0125 >> 2), 2'(i)});
            end
        end
    endtask

    task automatic conflict_eviction();
        fetch_word(16'h0a25); // same set, other tag
        fetch_word(16'h0125);
    endtask

    task automatic reset_invalidation();
        fetch_word(16'h0125);
        @(negedge clk);
        fetch      = 1'b1;
        fetch_addr = 16'h0330;
        repeat (3) @(negedge clk);
        check_value(32'(mem_read), 32'd1, "mem_read in the middle of a fill");
        hold_reset();
        fetch_word(16'h0125);
    endtask

    task automatic random_sequence();
        for (int n = 0; n < 200; n++) begin
            fetch_word(word_t'($urandom_range(63, 0))); // four tags compete for every set
        end
    endtask

    initial begin
        seed_value = $urandom(32'h745f_d8b7);
        fetch      = 1'b0;
        fetch_addr = '0;
        reset_n    = 1'b1;
        hold_reset();
        cold_miss();
        hit_after_fill();
        same_line_hits();
        conflict_eviction();
        reset_invalidation();
        random_sequence();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: icache_fill.f
+incdir+logic
logic/icache_types_pkg.sv
logic/icache_ctrl_pkg.sv
logic/icache_fill_ctrl.sv
logic/burst_counter.sv
logic/tag_store.sv
logic/line_store.sv
logic/icache_top.sv
tests/icache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = icache_tb
FILELIST  = icache_fill.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
